/* src/synth_defs.svh */
`ifndef SYNTH_DEFS_SVH
`define SYNTH_DEFS_SVH

// a MIDI data byte carries seven payload bits below a clear top bit
`define MIDI_DATA_WIDTH 7

// number of synth parameters behind the control change map
`define PARAM_COUNT 8

// index into the parameter bank, 0 is tempo and 7 is volume
`define PARAM_INDEX_WIDTH 3

`endif

/* src/synth_pkg.sv */
`default_nettype none

`include "synth_defs.svh"

package synth_pkg;

  // high nibble of a channel status byte
  typedef enum logic [3:0] {
    NOTE_OFF         = 4'h8,
    NOTE_ON          = 4'h9,
    POLY_PRESSURE    = 4'hA,
    CONTROL_CHANGE   = 4'hB,
    PROGRAM_CHANGE   = 4'hC,
    CHANNEL_PRESSURE = 4'hD,
    PITCH_BEND       = 4'hE
  } message_type_t;

  // controller numbers that map onto a synth parameter
  typedef enum logic [`MIDI_DATA_WIDTH-1:0] {
    VOLUME     = 7'd7,
    TEMPO      = 7'd14,
    UNISON     = 7'd15,
    DUTY_CYCLE = 7'd16,
    RELEASE    = 7'd72,
    ATTACK     = 7'd73,
    DECAY      = 7'd75,
    SUSTAIN    = 7'd79
  } controller_t;

  // id of the parameter touched by the last message, follows the struct order
  typedef enum logic [3:0] {
    PARAM_NONE          = 4'd0,
    PARAM_TEMPO         = 4'd1,
    PARAM_UNISON_DETUNE = 4'd2,
    PARAM_DUTY_CYCLE    = 4'd3,
    PARAM_ATTACK_TIME   = 4'd4,
    PARAM_DECAY_TIME    = 4'd5,
    PARAM_SUSTAIN_LEVEL = 4'd6,
    PARAM_RELEASE_TIME  = 4'd7,
    PARAM_VOLUME        = 4'd8
  } parameter_change_t;

  // tempo sits in the top bits, volume in the bottom bits
  typedef struct packed {
    logic [`MIDI_DATA_WIDTH-1:0] tempo;
    logic [`MIDI_DATA_WIDTH-1:0] unison_detune;
    logic [`MIDI_DATA_WIDTH-1:0] duty_cycle;
    logic [`MIDI_DATA_WIDTH-1:0] attack_time;
    logic [`MIDI_DATA_WIDTH-1:0] decay_time;
    logic [`MIDI_DATA_WIDTH-1:0] sustain_level;
    logic [`MIDI_DATA_WIDTH-1:0] release_time;
    logic [`MIDI_DATA_WIDTH-1:0] volume;
  } parameter_t;

endpackage : synth_pkg

`default_nettype wire

/* src/midi_message_if.sv */
`timescale 1ns/10ps
`default_nettype none

`include "synth_defs.svh"

interface midi_message_if import synth_pkg::*; ();

  message_type_t               message_type;
  logic [3:0]                  channel;
  logic [`MIDI_DATA_WIDTH-1:0] data_byte1;
  logic [`MIDI_DATA_WIDTH-1:0] data_byte2;
  logic                        message_ready;  // fields hold until the next pulse

  modport sender (
    output message_type, channel, data_byte1, data_byte2, message_ready
  );

  modport receiver (
    input message_type, channel, data_byte1, data_byte2, message_ready
  );

endinterface : midi_message_if

`default_nettype wire

/* src/midi_message_decoder.sv */
`timescale 1ns/10ps
`default_nettype none

`include "synth_defs.svh"

module midi_message_decoder import synth_pkg::*; (
  input  logic           clock_50_000_000,
  input  logic           reset_l,
  input  logic [7:0]     byte_data,
  input  logic           byte_strobe,
  midi_message_if.sender message
);

  typedef enum logic [1:0] {
    BYTE_DATA,
    BYTE_STATUS,
    BYTE_SYSTEM_COMMON,
    BYTE_REAL_TIME
  } byte_class_t;

  byte_class_t                 byte_class;
  message_type_t               byte_type;
  logic                        status_valid;
  message_type_t               status_type;
  logic [3:0]                  status_channel;
  logic [1:0]                  expected_count;
  logic [1:0]                  data_count;
  logic [`MIDI_DATA_WIDTH-1:0] first_data;
  logic                        data_accepted;
  logic                        message_done;

  always_comb begin
    if (!byte_data[7]) begin
      byte_class = BYTE_DATA;
    end else if (byte_data[7:4] != 4'hF) begin
      byte_class = BYTE_STATUS;
    end else if (!byte_data[3]) begin
      byte_class = BYTE_SYSTEM_COMMON;  // F0 to F7
    end else begin
      byte_class = BYTE_REAL_TIME;  // F8 to FF
    end
  end

  assign byte_type     = message_type_t'(byte_data[7:4]);
  assign data_accepted = byte_strobe && (byte_class == BYTE_DATA) && status_valid;
  assign message_done  = data_accepted && (data_count + 2'd1 == expected_count);

  always_ff @(posedge clock_50_000_000, negedge reset_l) begin
    if (!reset_l) begin
      status_valid          <= 1'b0;
      status_type           <= NOTE_OFF;
      status_channel        <= '0;
      expected_count        <= 2'd2;
      data_count            <= '0;
      message.message_ready <= 1'b0;
    end else begin
      message.message_ready <= message_done;
      if (byte_strobe) begin
        unique case (byte_class)
          BYTE_STATUS: begin
            status_valid   <= 1'b1;
            status_type    <= byte_type;
            status_channel <= byte_data[3:0];
            data_count     <= '0;
            if ((byte_type == PROGRAM_CHANGE) || (byte_type == CHANNEL_PRESSURE)) begin
              expected_count <= 2'd1;
            end else begin
              expected_count <= 2'd2;
            end
          end
          BYTE_SYSTEM_COMMON: begin
            status_valid <= 1'b0;  // running status is lost until the next status byte
            data_count   <= '0;
          end
          BYTE_DATA: begin
            if (status_valid) begin
              data_count <= message_done ? 2'd0 : data_count + 2'd1;
            end
          end
          default: begin
          end
        endcase
      end
    end
  end

  always_ff @(posedge clock_50_000_000) begin
    if (data_accepted && (data_count == 2'd0)) begin
      first_data <= byte_data[`MIDI_DATA_WIDTH-1:0];
    end
    if (message_done) begin
      message.message_type <= status_type;
      message.channel      <= status_channel;
      if (expected_count == 2'd1) begin
        message.data_byte1 <= byte_data[`MIDI_DATA_WIDTH-1:0];
        message.data_byte2 <= '0;  // single data byte messages leave the second one empty
      end else begin
        message.data_byte1 <= first_data;
        message.data_byte2 <= byte_data[`MIDI_DATA_WIDTH-1:0];
      end
    end
  end

endmodule : midi_message_decoder

`default_nettype wire

/* src/parameter_control.sv */
`timescale 1ns/10ps
`default_nettype none

`include "synth_defs.svh"

module parameter_control import synth_pkg::*; (
  input  logic              clock_50_000_000,
  input  logic              reset_l,
  midi_message_if.receiver  message,
  output parameter_t        parameters,
  output parameter_change_t parameter_changes,
  output logic              update
);

  controller_t                 controller;
  logic [`MIDI_DATA_WIDTH-1:0] value;

  assign controller = controller_t'(message.data_byte1);
  assign value      = message.data_byte2;

  always_ff @(posedge clock_50_000_000, negedge reset_l) begin
    if (!reset_l) begin
      parameters        <= '0;
      parameter_changes <= PARAM_NONE;
      update            <= 1'b0;
    end else begin
      update <= message.message_ready;  // marks the cycle the registers below took effect
      if (message.message_ready) begin
        unique case (message.message_type)
          CONTROL_CHANGE: begin
            unique case (controller)
              TEMPO: begin
                parameters.tempo  <= value;
                parameter_changes <= PARAM_TEMPO;
              end
              UNISON: begin
                parameters.unison_detune <= value;
                parameter_changes        <= PARAM_UNISON_DETUNE;
              end
              DUTY_CYCLE: begin
                parameters.duty_cycle <= value;
                parameter_changes     <= PARAM_DUTY_CYCLE;
              end
              ATTACK: begin
                parameters.attack_time <= value;
                parameter_changes      <= PARAM_ATTACK_TIME;
              end
              DECAY: begin
                parameters.decay_time <= value;
                parameter_changes     <= PARAM_DECAY_TIME;
              end
              SUSTAIN: begin
                parameters.sustain_level <= value;
                parameter_changes        <= PARAM_SUSTAIN_LEVEL;
              end
              RELEASE: begin
                parameters.release_time <= value;
                parameter_changes       <= PARAM_RELEASE_TIME;
              end
              VOLUME: begin
                parameters.volume <= value;
                parameter_changes <= PARAM_VOLUME;
              end
              default: begin
                parameter_changes <= PARAM_NONE;  // unmapped controller leaves the fields alone
              end
            endcase
          end
          default: begin
            parameter_changes <= PARAM_NONE;
          end
        endcase
      end
    end
  end

endmodule : parameter_control

`default_nettype wire

/* src/parameter_readout.sv */
`timescale 1ns/10ps
`default_nettype none

`include "synth_defs.svh"

module parameter_readout import synth_pkg::*; (
  input  logic                          clock_50_000_000,
  input  logic                          reset_l,
  input  parameter_t                    parameters,
  input  parameter_change_t             parameter_changes,
  input  logic                          update,
  input  logic [`PARAM_INDEX_WIDTH-1:0] read_select,
  output logic [`MIDI_DATA_WIDTH-1:0]   read_value,
  output logic                          change_valid,
  output parameter_change_t             change_id,
  output logic [`MIDI_DATA_WIDTH-1:0]   change_value
);

  logic [`PARAM_INDEX_WIDTH-1:0] change_index;
  logic                          change_pending;

  // index 0 is the first struct field, which sits in the top bits
  function automatic logic [`MIDI_DATA_WIDTH-1:0] field_at(
    input parameter_t                    fields,
    input logic [`PARAM_INDEX_WIDTH-1:0] index
  );
    return fields[(`PARAM_COUNT - 1 - index) * `MIDI_DATA_WIDTH +: `MIDI_DATA_WIDTH];
  endfunction

  assign change_index   = `PARAM_INDEX_WIDTH'(parameter_changes - 4'd1);  // ids start at 1
  assign change_pending = update && (parameter_changes != PARAM_NONE);
  assign read_value     = field_at(parameters, read_select);

  always_ff @(posedge clock_50_000_000, negedge reset_l) begin
    if (!reset_l) begin
      change_valid <= 1'b0;
      change_id    <= PARAM_NONE;
      change_value <= '0;
    end else begin
      change_valid <= change_pending;
      if (change_pending) begin
        change_id    <= parameter_changes;
        change_value <= field_at(parameters, change_index);
      end
    end
  end

endmodule : parameter_readout

`default_nettype wire

/* src/synth_control.sv */
`timescale 1ns/10ps
`default_nettype none

`include "synth_defs.svh"

module synth_control import synth_pkg::*; (
  input  logic                          clock_50_000_000,
  input  logic                          reset_l,
  input  logic [7:0]                    byte_data,
  input  logic                          byte_strobe,
  input  logic [`PARAM_INDEX_WIDTH-1:0] read_select,
  output logic [`MIDI_DATA_WIDTH-1:0]   read_value,
  output parameter_t                    parameters,
  output logic                          change_valid,
  output parameter_change_t             change_id,
  output logic [`MIDI_DATA_WIDTH-1:0]   change_value
);

  parameter_change_t parameter_changes;
  logic              update;

  midi_message_if message ();

  midi_message_decoder decoder (
    .clock_50_000_000 (clock_50_000_000),
    .reset_l          (reset_l),
    .byte_data        (byte_data),
    .byte_strobe      (byte_strobe),
    .message          (message.sender)
  );

  parameter_control control (
    .clock_50_000_000  (clock_50_000_000),
    .reset_l           (reset_l),
    .message           (message.receiver),
    .parameters        (parameters),
    .parameter_changes (parameter_changes),
    .update            (update)
  );

  parameter_readout readout (
    .clock_50_000_000  (clock_50_000_000),
    .reset_l           (reset_l),
    .parameters        (parameters),
    .parameter_changes (parameter_changes),
    .update            (update),
    .read_select       (read_select),
    .read_value        (read_value),
    .change_valid      (change_valid),
    .change_id         (change_id),
    .change_value      (change_value)
  );

endmodule : synth_control

`default_nettype wire

/* sim/synth_control_props.sv */
`timescale 1ns/10ps
`default_nettype none

module synth_control_props import synth_pkg::*; (
  input logic              clock_50_000_000,
  input logic              reset_l,
  input logic              message_ready,
  input logic              update,
  input parameter_change_t parameter_changes,
  input logic              change_valid
);

  update_after_ready : assert property (
    @(posedge clock_50_000_000) disable iff (!reset_l) update == $past(message_ready)
  ) else $error("update did not follow message_ready by one cycle");

  // only updates that name a parameter turn into change events
  event_after_update : assert property (
    @(posedge clock_50_000_000) disable iff (!reset_l)
      change_valid == $past(update && (parameter_changes != PARAM_NONE))
  ) else $error("change_valid did not follow an update with a real id by one cycle");

  single_cycle_event : assert property (
    @(posedge clock_50_000_000) disable iff (!reset_l) change_valid |=> !change_valid
  ) else $error("change_valid stayed high for two cycles in a row");

endmodule : synth_control_props

// watches the control and readout stages from the top level that holds both
bind synth_control synth_control_props props (
  .clock_50_000_000  (clock_50_000_000),
  .reset_l           (reset_l),
  .message_ready     (message.message_ready),
  .update            (update),
  .parameter_changes (parameter_changes),
  .change_valid      (change_valid)
);

`default_nettype wire

/* sim/synth_control_tb.sv */
`timescale 1ns/10ps
`default_nettype none

`include "synth_defs.svh"

module synth_control_tb import synth_pkg::*; ();

  localparam int event_timeout = 50;  // cycles allowed for expected events to drain
  localparam logic [6:0] known_controllers [8] = '{
    7'd14, 7'd15, 7'd16, 7'd73, 7'd75, 7'd79, 7'd72, 7'd7
  };

  logic                          clock_50_000_000;
  logic                          reset_l;
  logic [7:0]                    byte_data;
  logic                          byte_strobe;
  logic [`PARAM_INDEX_WIDTH-1:0] read_select;
  logic [`MIDI_DATA_WIDTH-1:0]   read_value;
  parameter_t                    parameters;
  logic                          change_valid;
  parameter_change_t             change_id;
  logic [`MIDI_DATA_WIDTH-1:0]   change_value;

  parameter_t                    model_params;
  logic                          model_status_valid;
  logic [3:0]                    model_kind;
  logic [`MIDI_DATA_WIDTH-1:0]   model_first;
  int                            model_needed;
  int                            model_seen;
  parameter_change_t             expected_ids [$];
  logic [`MIDI_DATA_WIDTH-1:0]   expected_values [$];
  int                            expected_cycles [$];
  int                            cycle_count = 0;
  string                         current_test;
  int                            error_count = 0;
  int                            test_errors = 0;
  int                            test_count = 0;
  int                            failed_tests = 0;
  int                            seed = 32'h8781676e;

  synth_control uut (
    .clock_50_000_000 (clock_50_000_000),
    .reset_l          (reset_l),
    .byte_data        (byte_data),
    .byte_strobe      (byte_strobe),
    .read_select      (read_select),
    .read_value       (read_value),
    .parameters       (parameters),
    .change_valid     (change_valid),
    .change_id        (change_id),
    .change_value     (change_value)
  );

  initial begin
    clock_50_000_000 = 1'b0;
    forever #10 clock_50_000_000 = ~clock_50_000_000;
  end

  always @(posedge clock_50_000_000) begin
    cycle_count++;
  end

  // expected id for one decoded message, and the parameter model after it
  function automatic parameter_change_t expected_event(
    input  logic [3:0]                  kind,
    input  logic [`MIDI_DATA_WIDTH-1:0] number,
    input  logic [`MIDI_DATA_WIDTH-1:0] value,
    input  parameter_t                  model,
    output parameter_t                  updated
  );
    parameter_change_t id;
    case (number)
      TEMPO:      id = PARAM_TEMPO;
      UNISON:     id = PARAM_UNISON_DETUNE;
      DUTY_CYCLE: id = PARAM_DUTY_CYCLE;
      ATTACK:     id = PARAM_ATTACK_TIME;
      DECAY:      id = PARAM_DECAY_TIME;
      SUSTAIN:    id = PARAM_SUSTAIN_LEVEL;
      RELEASE:    id = PARAM_RELEASE_TIME;
      VOLUME:     id = PARAM_VOLUME;
      default:    id = PARAM_NONE;
    endcase
    if (kind != CONTROL_CHANGE) begin
      id = PARAM_NONE;
    end
    updated = model;
    case (id)
      PARAM_TEMPO:         updated.tempo         = value;
      PARAM_UNISON_DETUNE: updated.unison_detune = value;
      PARAM_DUTY_CYCLE:    updated.duty_cycle    = value;
      PARAM_ATTACK_TIME:   updated.attack_time   = value;
      PARAM_DECAY_TIME:    updated.decay_time    = value;
      PARAM_SUSTAIN_LEVEL: updated.sustain_level = value;
      PARAM_RELEASE_TIME:  updated.release_time  = value;
      PARAM_VOLUME:        updated.volume        = value;
      default:             updated = model;
    endcase
    return id;
  endfunction

  function automatic logic [`MIDI_DATA_WIDTH-1:0] field_value(
    input parameter_t                    model,
    input logic [`PARAM_INDEX_WIDTH-1:0] index
  );
    case (index)
      3'd0:    return model.tempo;
      3'd1:    return model.unison_detune;
      3'd2:    return model.duty_cycle;
      3'd3:    return model.attack_time;
      3'd4:    return model.decay_time;
      3'd5:    return model.sustain_level;
      3'd6:    return model.release_time;
      default: return model.volume;
    endcase
  endfunction

  // byte level model of the decoder that queues every event it predicts
  task automatic track_byte(input logic [7:0] value);
    parameter_change_t           id;
    logic [`MIDI_DATA_WIDTH-1:0] number;
    logic [`MIDI_DATA_WIDTH-1:0] data;
    if (value >= 8'hF8) begin
      return;  // real-time bytes leave everything as it was
    end
    if (value >= 8'hF0) begin
      model_status_valid = 1'b0;
      model_seen         = 0;
    end else if (value[7]) begin
      model_status_valid = 1'b1;
      model_kind         = value[7:4];
      model_seen         = 0;
      model_needed       = (value[7:4] == 4'hC || value[7:4] == 4'hD) ? 1 : 2;
    end else if (model_status_valid) begin
      if (model_seen == 0) begin
        model_first = value[6:0];
      end
      model_seen++;
      if (model_seen == model_needed) begin
        model_seen = 0;
        number     = (model_needed == 1) ? value[6:0] : model_first;
        data       = (model_needed == 1) ? 7'd0 : value[6:0];
        id         = expected_event(model_kind, number, data, model_params, model_params);
        if (id != PARAM_NONE) begin
          expected_ids.push_back(id);
          expected_values.push_back(data);
          expected_cycles.push_back(cycle_count + 3);  // three cycles after the final byte
        end
      end
    end
  endtask

  task automatic reset_model();
    model_params       = '0;
    model_status_valid = 1'b0;
    model_seen         = 0;
    expected_ids.delete();
    expected_values.delete();
    expected_cycles.delete();
  endtask

  task automatic apply_reset();
    @(negedge clock_50_000_000);
    reset_l     = 1'b0;
    byte_strobe = 1'b0;
    reset_model();
    repeat (3) @(negedge clock_50_000_000);
    reset_l = 1'b1;
  endtask

  task automatic send_byte(input logic [7:0] value);
    @(negedge clock_50_000_000);
    byte_data   = value;
    byte_strobe = 1'b1;
    track_byte(value);
  endtask

  task automatic release_strobe();
    @(negedge clock_50_000_000);
    byte_strobe = 1'b0;
  endtask

  // bytes go out back to back with the most significant byte of the stream first
  task automatic send_bytes(input logic [63:0] stream, input int count);
    int k;
    for (k = count - 1; k >= 0; k--) begin
      send_byte(stream[k * 8 +: 8]);
    end
    release_strobe();
  endtask

  task automatic check_change(
    input string                       name,
    input parameter_change_t           expected_id,
    input logic [`MIDI_DATA_WIDTH-1:0] expected_value
  );
    if (change_id !== expected_id || change_value !== expected_value) begin
      $display("** Error: %s change event expected %s=%0d, actual %s=%0d", name,
               expected_id.name(), expected_value, change_id.name(), change_value);
      error_count++;
    end
  endtask

  task automatic check_latency(
    input string name,
    input int    expected_cycle,
    input int    actual_cycle
  );
    if (actual_cycle != expected_cycle) begin
      $display("** Error: %s change event cycle expected %0d, actual %0d", name,
               expected_cycle, actual_cycle);
      error_count++;
    end
  endtask

  task automatic check_parameters(input string name, input parameter_t expected);
    int                          i;
    logic [`MIDI_DATA_WIDTH-1:0] field;
    if (parameters !== expected) begin
      $display("** Error: %s parameters expected %h, actual %h", name, expected, parameters);
      error_count++;
    end
    for (i = 0; i < `PARAM_COUNT; i++) begin
      @(negedge clock_50_000_000);
      read_select = `PARAM_INDEX_WIDTH'(i);
      #5;
      field = field_value(expected, read_select);
      if (read_value !== field) begin
        $display("** Error: %s read_value[%0d] expected %0d, actual %0d", name, i, field,
                 read_value);
        error_count++;
      end
    end
  endtask

  task automatic drain_events();
    int cycles;
    cycles = 0;
    while (expected_ids.size() != 0 && cycles < event_timeout) begin
      @(negedge clock_50_000_000);
      cycles++;
    end
    if (expected_ids.size() != 0) begin
      $display("%s: %0d expected change events never arrived on change_valid", current_test,
               expected_ids.size());
      error_count++;
      expected_ids.delete();
      expected_values.delete();
      expected_cycles.delete();
    end
  endtask

  task automatic start_test(input string name);
    current_test = name;
    test_errors  = error_count;
  endtask

  task automatic finish_test();
    drain_events();
    repeat (4) @(negedge clock_50_000_000);  // lets any unexpected event show up
    check_parameters(current_test, model_params);
    test_count++;
    if (error_count == test_errors) begin
      $display("%s: passed", current_test);
    end else begin
      $display("%s: failed with %0d errors", current_test, error_count - test_errors);
      failed_tests++;
    end
  endtask

  always @(negedge clock_50_000_000) begin
    if (reset_l && change_valid) begin
      if (expected_ids.size() == 0) begin
        $display("%s: change event for %s arrived when none was expected", current_test,
                 change_id.name());
        error_count++;
      end else begin
        check_latency(current_test, expected_cycles.pop_front(), cycle_count);
        check_change(current_test, expected_ids.pop_front(), expected_values.pop_front());
      end
    end
  end

  initial begin
    int          i;
    logic [31:0] pick;
    reset_l      = 1'b0;
    byte_data    = 8'h00;
    byte_strobe  = 1'b0;
    read_select  = '0;
    current_test = "reset";
    reset_model();
    apply_reset();

    start_test("controller_map");
    for (i = 0; i < 8; i++) begin
      send_bytes(64'({8'hB3, 1'b0, known_controllers[i], 8'(32 + i * 11)}), 3);
    end
    finish_test();

    start_test("running_status");
    send_bytes(64'hB5_07_11_0E_22_10_33, 7);
    send_bytes(64'hB0_49_15_B7_4B_26, 6);
    send_bytes(64'hBF_4F_37_48_5A, 5);
    finish_test();

    start_test("ignored_messages");
    send_bytes(64'hB2_01_40_40_7F_7B_00, 7);  // modulation, pedal and all notes off
    send_bytes(64'h93_3C_64_C4_05_06_07, 7);
    send_bytes(64'hE0_00_40_D1_10, 5);
    finish_test();

    start_test("system_bytes");
    send_bytes(64'hB6_F8_07_FE_55, 5);
    send_bytes(64'hB6_0E_F9_21_FF, 5);
    send_bytes(64'hF2_0E_30_10_31, 5);
    send_bytes(64'hB0_10_12_F1_0F_30, 6);
    finish_test();

    start_test("random_stream");
    for (i = 0; i < 400; i++) begin
      pick = $random(seed);
      case (pick[3:0])
        4'd0, 4'd1:             send_byte({4'hB, pick[7:4]});
        4'd2:                   send_byte({1'b1, pick[10:4]});
        4'd3:                   send_byte({5'b11111, pick[6:4]});
        4'd4, 4'd5, 4'd6, 4'd7: send_byte({1'b0, known_controllers[pick[6:4]]});
        default:                send_byte({1'b0, pick[10:4]});
      endcase
      if (pick[12]) begin
        release_strobe();
      end
    end
    release_strobe();
    finish_test();

    start_test("reset_mid_stream");
    send_bytes(64'hB8_4F_2A, 3);
    drain_events();
    send_bytes(64'hB8_48, 2);  // half a release message is left in the decoder
    apply_reset();
    send_bytes(64'h15_4B_3C, 3);
    send_bytes(64'hB1_4B_3C, 3);
    finish_test();

    $display("%0d tests, %0d failed, %0d errors", test_count, failed_tests, error_count);
    if (error_count == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

endmodule : synth_control_tb

`default_nettype wire

/* vlog.f */
+incdir+src
src/synth_pkg.sv
src/midi_message_if.sv
src/midi_message_decoder.sv
src/parameter_control.sv
src/parameter_readout.sv
src/synth_control.sv
sim/synth_control_props.sv
sim/synth_control_tb.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= synth_control_tb
FILE_LIST ?= vlog.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing --assert

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILE_LIST)

sim:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILE_LIST)
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -qx "Result: PASSED" $(LOG); then \
	  echo "simulation passed, see $(LOG)"; \
	else \
	  echo "simulation failed, see $(LOG)"; \
	  exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
